// File: files.f
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_exec.sv
hw/rv_csr.sv
hw/rv_bus_arb.sv
hw/rv_top_wb.sv
sim/tb_wb_mem.sv
sim/tb_rv_top.sv

// File: hw/rv_bus_arb.sv
`timescale 1ns/1ps

module rv_bus_arb
#(
    parameter logic [31:0] RESET_ADDR       = 32'h0000_0000,
    parameter int          IADDR_SPACE_BITS = 16
)
(
    input  wire                         i_clk,
    input  wire                         i_arst_n,
    input  wire                         i_instr_req,
    input  wire [IADDR_SPACE_BITS-1:0]  i_instr_addr,
    output logic                        o_instr_ack,
    output logic [31:0]                 o_instr_data,
    input  wire                         i_data_req,
    input  wire                         i_data_write,
    input  wire [31:0]                  i_data_addr,
    input  wire [31:0]                  i_data_wdata,
    output logic                        o_data_ack,
    output logic [31:0]                 o_data_rdata,
    output logic [31:0]                 o_wb_adr,
    output logic [31:0]                 o_wb_dat,
    output logic                        o_wb_we,
    output logic [3:0]                  o_wb_sel,
    output logic                        o_wb_stb,
    output logic                        o_wb_cyc,
    input  wire [31:0]                  i_wb_dat,
    input  wire                         i_wb_ack
);

    // fetch address bits; the rest come from RESET_ADDR
    localparam logic [31:0] IMASK = (IADDR_SPACE_BITS >= 32) ? '1 :
                                    (32'd1 << IADDR_SPACE_BITS) - 32'd1;

    typedef enum logic [1:0] {S_IDLE, S_INSTR, S_DATA, S_HOLD} state_t;

    state_t      state;
    logic [31:0] rdata;

    assign o_instr_data = rdata;
    assign o_data_rdata = rdata;
    assign o_wb_sel     = '1;       // word accesses only

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state       <= S_IDLE;
            o_wb_cyc    <= 1'b0;
            o_wb_stb    <= 1'b0;
            o_wb_we     <= 1'b0;
            o_instr_ack <= 1'b0;
            o_data_ack  <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (i_data_req)     // data first
                    begin
                        state    <= S_DATA;
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        o_wb_we  <= i_data_write;
                    end
                    else if (i_instr_req)
                    begin
                        state    <= S_INSTR;
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        o_wb_we  <= 1'b0;
                    end
                end
                S_INSTR, S_DATA:
                begin
                    if (i_wb_ack)
                    begin
                        state       <= S_HOLD;
                        o_wb_cyc    <= 1'b0;
                        o_wb_stb    <= 1'b0;
                        o_wb_we     <= 1'b0;
                        o_instr_ack <= (state == S_INSTR);
                        o_data_ack  <= (state == S_DATA);
                    end
                end
                default:            // hold ack until the requester drops req
                begin
                    if ((o_instr_ack && !i_instr_req) || (o_data_ack && !i_data_req))
                    begin
                        state       <= S_IDLE;
                        o_instr_ack <= 1'b0;
                        o_data_ack  <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (state == S_IDLE)
        begin
            o_wb_adr <= i_data_req ? i_data_addr
                                   : (RESET_ADDR & ~IMASK) | 32'(i_instr_addr);
            o_wb_dat <= i_data_wdata;
        end
        if (i_wb_ack && (state == S_INSTR || state == S_DATA))
            rdata <= i_wb_dat;
    end

    // slave acks only inside an open bus cycle
    a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wb_ack |-> o_wb_cyc && o_wb_stb);

endmodule

// File: hw/rv_csr.sv
`timescale 1ns/1ps

module rv_csr
(
    input  wire                             i_clk,
    input  wire                             i_arst_n,
    input  rv_pkg::csr_op_t                 i_csr_op,
    input  wire [rv_pkg::CSR_ADDR_W-1:0]    i_csr_addr,
    input  wire [31:0]                      i_csr_wdata,
    input  wire                             i_retire,
    output logic [31:0]                     o_csr_rdata
);

    import rv_pkg::*;

    logic [XLEN-1:0] mcycle;
    logic [XLEN-1:0] minstret;
    logic [XLEN-1:0] mscratch;

    always_comb
    begin
        case (i_csr_addr)
            CSR_MCYCLE:   o_csr_rdata = mcycle;
            CSR_MINSTRET: o_csr_rdata = minstret;     // excludes the reading instruction
            CSR_MSCRATCH: o_csr_rdata = mscratch;
            default:      o_csr_rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            mcycle   <= '0;
            minstret <= '0;
            mscratch <= '0;
        end
        else
        begin
            mcycle <= mcycle + 1'b1;
            if (i_retire)
                minstret <= minstret + 1'b1;
            // counters are read-only here, so only mscratch takes writes
            if (i_csr_addr == CSR_MSCRATCH)
            begin
                if (i_csr_op == CSR_WRITE)
                    mscratch <= i_csr_wdata;
                else if (i_csr_op == CSR_SET)
                    mscratch <= mscratch | i_csr_wdata;
            end
        end
    end

endmodule

// File: hw/rv_exec.sv
`timescale 1ns/1ps

module rv_exec
#(
    parameter int IADDR_SPACE_BITS = 16
)
(
    input  wire                             i_clk,
    input  wire                             i_arst_n,
    input  wire                             i_fetch_valid,
    input  wire [31:0]                      i_fetch_instr,
    input  wire [IADDR_SPACE_BITS-1:0]      i_fetch_pc,
    output logic                            o_take,
    output logic                            o_redirect,
    output logic [IADDR_SPACE_BITS-1:0]     o_redirect_pc,
    output logic                            o_data_req,
    output logic                            o_data_write,
    output logic [31:0]                     o_data_addr,
    output logic [31:0]                     o_data_wdata,
    input  wire                             i_data_ack,
    input  wire [31:0]                      i_data_rdata,
    output rv_pkg::csr_op_t                 o_csr_op,
    output logic [rv_pkg::CSR_ADDR_W-1:0]   o_csr_addr,
    output logic [31:0]                     o_csr_wdata,
    output logic                            o_retire,
    input  wire [31:0]                      i_csr_rdata
);

    import rv_pkg::*;

    logic [XLEN-1:0]     regs [1:31];
    logic [OPCODE_W-1:0] opcode;
    logic [REG_W-1:0]    rd, rs1, rs2, mem_rd, wr_rd;
    logic [F3_W-1:0]     f3;
    logic [F7_W-1:0]     f7;
    logic [XLEN-1:0]     rs1_val, rs2_val, imm_i, imm_s, imm_b, imm_u;
    logic [XLEN-1:0]     result, wr_data;
    logic                wb_en, is_mem, br_taken, load_done, wr_en;
    csr_op_t             csr_op;

    //////////////////////////////
    // decode
    assign opcode = i_fetch_instr[6:0];
    assign rd     = i_fetch_instr[11:7];
    assign f3     = i_fetch_instr[14:12];
    assign rs1    = i_fetch_instr[19:15];
    assign rs2    = i_fetch_instr[24:20];
    assign f7     = i_fetch_instr[31:25];

    assign imm_i = {{20{i_fetch_instr[31]}}, i_fetch_instr[31:20]};
    assign imm_s = {{20{i_fetch_instr[31]}}, i_fetch_instr[31:25], i_fetch_instr[11:7]};
    assign imm_b = {{19{i_fetch_instr[31]}}, i_fetch_instr[31], i_fetch_instr[7],
                    i_fetch_instr[30:25], i_fetch_instr[11:8], 1'b0};
    assign imm_u = {i_fetch_instr[31:12], 12'b0};

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    always_comb
    begin
        wb_en    = 1'b0;
        is_mem   = 1'b0;
        br_taken = 1'b0;
        result   = '0;
        csr_op   = CSR_NONE;
        case (opcode)
            OP_LUI:
            begin
                wb_en  = 1'b1;
                result = imm_u;
            end
            OP_OPIMM:
            begin
                wb_en  = (f3 == F3_ADD);
                result = rs1_val + imm_i;
            end
            OP_OP:
            begin
                wb_en  = (f3 == F3_ADD);
                result = (f7 == F7_SUB) ? rs1_val - rs2_val : rs1_val + rs2_val;
            end
            OP_LOAD:   is_mem = (f3 == F3_LW);
            OP_STORE:  is_mem = (f3 == F3_SW);
            OP_BRANCH: br_taken = (f3 == F3_BNE) && (rs1_val != rs2_val);
            OP_SYSTEM:
            begin
                if (f3 == F3_CSRRW)
                    csr_op = CSR_WRITE;
                else if (f3 == F3_CSRRS)
                    csr_op = CSR_SET;
                wb_en  = (csr_op != CSR_NONE);
                result = i_csr_rdata;       // old value goes to rd
            end
            default: ;                      // anything else retires as a no-op
        endcase
    end

    // one instruction at a time, and only once the data exchange has closed
    assign o_take        = i_fetch_valid && !o_data_req && !i_data_ack;
    assign o_redirect    = o_take && br_taken;
    assign o_redirect_pc = i_fetch_pc + imm_b[IADDR_SPACE_BITS-1:0];

    assign o_csr_op    = o_take ? csr_op : CSR_NONE;
    assign o_csr_addr  = i_fetch_instr[31:20];
    assign o_csr_wdata = rs1_val;

    assign load_done = o_data_req && i_data_ack && !o_data_write;
    assign o_retire  = (o_take && !is_mem) || (o_data_req && i_data_ack);

    //////////////////////////////
    // register file
    assign wr_en   = (o_take && wb_en) || load_done;
    assign wr_rd   = load_done ? mem_rd : rd;
    assign wr_data = load_done ? i_data_rdata : result;

    always_ff @(posedge i_clk)
    begin
        if (wr_en && wr_rd != '0)
            regs[wr_rd] <= wr_data;
    end

    //////////////////////////////
    // load/store exchange
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_data_req <= 1'b0;
        else if (o_take && is_mem)
            o_data_req <= 1'b1;
        else if (i_data_ack)
            o_data_req <= 1'b0;
    end

    always_ff @(posedge i_clk)
    begin
        if (o_take && is_mem)
        begin
            o_data_write <= (opcode == OP_STORE);
            o_data_addr  <= rs1_val + ((opcode == OP_STORE) ? imm_s : imm_i);
            o_data_wdata <= rs2_val;
            mem_rd       <= rd;
        end
    end

    // ack falls one cycle after req falls
    a_data_ack_release: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_data_ack && !o_data_req |=> !i_data_ack);

endmodule

// File: hw/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch
#(
    parameter logic [31:0] RESET_ADDR    = 32'h0000_0000,
    parameter int          IADDR_SPACE_BITS = 16
)
(
    input  wire                         i_clk,
    input  wire                         i_arst_n,
    input  wire                         i_take,
    input  wire                         i_redirect,
    input  wire [IADDR_SPACE_BITS-1:0]  i_redirect_pc,
    output logic                        o_instr_req,
    output logic [IADDR_SPACE_BITS-1:0] o_instr_addr,
    input  wire                         i_instr_ack,
    input  wire [31:0]                  i_instr_data,
    output logic                        o_fetch_valid,
    output logic [31:0]                 o_fetch_instr,
    output logic [IADDR_SPACE_BITS-1:0] o_fetch_pc
);

    logic [IADDR_SPACE_BITS-1:0] pc;
    logic                        ack_first;
    logic                        start;

    assign ack_first = o_instr_req && i_instr_ack;   // data valid here
    // new request only once the previous exchange has fully closed
    assign start = !o_instr_req && !i_instr_ack && !o_fetch_valid && !i_redirect;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            pc            <= RESET_ADDR[IADDR_SPACE_BITS-1:0];
            o_instr_req   <= 1'b0;
            o_fetch_valid <= 1'b0;
        end
        else
        begin
            if (ack_first)
                o_instr_req <= 1'b0;
            else if (start)
                o_instr_req <= 1'b1;

            if (i_redirect)
            begin
                pc            <= i_redirect_pc;
                o_fetch_valid <= 1'b0;
            end
            else
            begin
                if (i_take)
                    o_fetch_valid <= 1'b0;
                if (ack_first)
                begin
                    o_fetch_valid <= 1'b1;
                    pc            <= pc + IADDR_SPACE_BITS'(4);
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (start)
            o_instr_addr <= pc;
        if (ack_first)
        begin
            o_fetch_instr <= i_instr_data;
            o_fetch_pc    <= o_instr_addr;
        end
    end

    // ack falls one cycle after req falls
    a_instr_ack_release: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_instr_ack && !o_instr_req |=> !i_instr_ack);

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;

    // instruction field widths
    localparam int OPCODE_W   = 7;
    localparam int REG_W      = 5;
    localparam int F3_W       = 3;
    localparam int F7_W       = 7;
    localparam int CSR_ADDR_W = 12;

    //////////////////////////////
    // opcodes
    localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OP_OPIMM  = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_OP     = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_SYSTEM = 7'b1110011;

    //////////////////////////////
    // funct fields
    localparam logic [F3_W-1:0] F3_ADD   = 3'b000;
    localparam logic [F3_W-1:0] F3_BNE   = 3'b001;
    localparam logic [F3_W-1:0] F3_LW    = 3'b010;
    localparam logic [F3_W-1:0] F3_SW    = 3'b010;
    localparam logic [F3_W-1:0] F3_CSRRW = 3'b001;
    localparam logic [F3_W-1:0] F3_CSRRS = 3'b010;

    localparam logic [F7_W-1:0] F7_SUB   = 7'b0100000;

    //////////////////////////////
    // csr map
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE   = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;

    typedef enum logic [1:0]
    {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2
    } csr_op_t;

endpackage

// File: hw/rv_top_wb.sv
`timescale 1ns/1ps

module rv_top_wb
#(
    parameter logic [31:0] RESET_ADDR       = 32'h0000_0000,
    parameter int          IADDR_SPACE_BITS = 16
)
(
    input  wire         i_clk,
    input  wire         i_arst_n,
    output logic [31:0] o_wb_adr,
    output logic [31:0] o_wb_dat,
    input  wire  [31:0] i_wb_dat,
    output logic        o_wb_we,
    output logic [3:0]  o_wb_sel,
    output logic        o_wb_stb,
    input  wire         i_wb_ack,
    output logic        o_wb_cyc
);

    import rv_pkg::*;

    generate
        if (IADDR_SPACE_BITS > 32)
        begin : g_cfg_check
            $error("IADDR_SPACE_BITS must not exceed 32");
        end
    endgenerate

    logic                        instr_req, instr_ack;
    logic [IADDR_SPACE_BITS-1:0] instr_addr;
    logic [31:0]                 instr_data;
    logic                        data_req, data_write, data_ack;
    logic [31:0]                 data_addr, data_wdata, data_rdata;

    logic                        take, redirect, fetch_valid;
    logic [IADDR_SPACE_BITS-1:0] redirect_pc, fetch_pc;
    logic [31:0]                 fetch_instr;

    csr_op_t                     csr_op;
    logic [CSR_ADDR_W-1:0]       csr_addr;
    logic [31:0]                 csr_wdata, csr_rdata;
    logic                        retire;

    rv_fetch #(.RESET_ADDR(RESET_ADDR), .IADDR_SPACE_BITS(IADDR_SPACE_BITS)) u_fetch
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_take         (take),
        .i_redirect     (redirect),
        .i_redirect_pc  (redirect_pc),
        .o_instr_req    (instr_req),
        .o_instr_addr   (instr_addr),
        .i_instr_ack    (instr_ack),
        .i_instr_data   (instr_data),
        .o_fetch_valid  (fetch_valid),
        .o_fetch_instr  (fetch_instr),
        .o_fetch_pc     (fetch_pc)
    );

    rv_exec #(.IADDR_SPACE_BITS(IADDR_SPACE_BITS)) u_exec
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_fetch_valid  (fetch_valid),
        .i_fetch_instr  (fetch_instr),
        .i_fetch_pc     (fetch_pc),
        .o_take         (take),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_data_req     (data_req),
        .o_data_write   (data_write),
        .o_data_addr    (data_addr),
        .o_data_wdata   (data_wdata),
        .i_data_ack     (data_ack),
        .i_data_rdata   (data_rdata),
        .o_csr_op       (csr_op),
        .o_csr_addr     (csr_addr),
        .o_csr_wdata    (csr_wdata),
        .o_retire       (retire),
        .i_csr_rdata    (csr_rdata)
    );

    rv_csr u_csr
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_csr_op       (csr_op),
        .i_csr_addr     (csr_addr),
        .i_csr_wdata    (csr_wdata),
        .i_retire       (retire),
        .o_csr_rdata    (csr_rdata)
    );

    rv_bus_arb #(.RESET_ADDR(RESET_ADDR), .IADDR_SPACE_BITS(IADDR_SPACE_BITS)) u_arb
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_instr_req    (instr_req),
        .i_instr_addr   (instr_addr),
        .o_instr_ack    (instr_ack),
        .o_instr_data   (instr_data),
        .i_data_req     (data_req),
        .i_data_write   (data_write),
        .i_data_addr    (data_addr),
        .i_data_wdata   (data_wdata),
        .o_data_ack     (data_ack),
        .o_data_rdata   (data_rdata),
        .o_wb_adr       (o_wb_adr),
        .o_wb_dat       (o_wb_dat),
        .o_wb_we        (o_wb_we),
        .o_wb_sel       (o_wb_sel),
        .o_wb_stb       (o_wb_stb),
        .o_wb_cyc       (o_wb_cyc),
        .i_wb_dat       (i_wb_dat),
        .i_wb_ack       (i_wb_ack)
    );

endmodule

// File: sim/tb_rv_top.sv
`timescale 1ns/1ps

module tb_rv_top;

    import rv_pkg::*;

    localparam int          TIMEOUT_CYCLES = 200 * 4 * 4;    // accesses x cycles x worst delay
    localparam logic [31:0] PROG_BYTES     = 32'h100;
    localparam logic [31:0] LOAD_ADDR      = 32'h200;
    localparam logic [31:0] LOAD_WORD      = 32'hCAFE_0A51;
    localparam logic [31:0] STORE_BASE     = 32'h300;
    localparam int          K_EXACT        = 0;
    localparam int          K_FIRST        = 1;
    localparam int          K_LATER        = 2;

    logic        clk   = 1'b0;
    logic        rst_n;
    logic        rst_d = 1'b0;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic        wb_stb;
    logic        wb_cyc;
    logic        wb_ack;

    int          cycles   = 0;
    int          n_seen   = 0;
    int          prog_idx = 0;
    logic [31:0] mcycle_first;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_kind [$];

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        rst_d  <= rst_n;
    end

    rv_top_wb #(.RESET_ADDR(32'h0000_0000), .IADDR_SPACE_BITS(16)) u_dut
    (
        .i_clk      (clk),
        .i_arst_n   (rst_n),
        .o_wb_adr   (wb_adr),
        .o_wb_dat   (wb_dat_w),
        .i_wb_dat   (wb_dat_r),
        .o_wb_we    (wb_we),
        .o_wb_sel   (wb_sel),
        .o_wb_stb   (wb_stb),
        .i_wb_ack   (wb_ack),
        .o_wb_cyc   (wb_cyc)
    );

    tb_wb_mem #(.SEED(32'h0b42c883)) u_mem
    (
        .i_clk      (clk),
        .i_arst_n   (rst_n),
        .i_wb_adr   (wb_adr),
        .i_wb_dat   (wb_dat_w),
        .i_wb_we    (wb_we),
        .i_wb_sel   (wb_sel),
        .i_wb_stb   (wb_stb),
        .i_wb_cyc   (wb_cyc),
        .o_wb_dat   (wb_dat_r),
        .o_wb_ack   (wb_ack)
    );

    //////////////////////////////
    // instruction encoders
    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [6:0] op);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    task automatic place_instr(input logic [31:0] w);
        u_mem.mem[prog_idx] = w;
        prog_idx = prog_idx + 1;
    endtask

    task automatic expect_store(input logic [31:0] a, input logic [31:0] d, input int k);
        exp_addr.push_back(a);
        exp_data.push_back(d);
        exp_kind.push_back(k);
    endtask

    task automatic load_program();
        for (int i = 0; i < 256; i++)
            u_mem.mem[i] = 32'hA5A5_0000 | i;
        place_instr(itype(STORE_BASE[11:0], 5'd0, F3_ADD, 5'd10, OP_OPIMM));
        place_instr(utype(20'h12345, 5'd1, OP_LUI));
        place_instr(stype(12'd0, 5'd1, 5'd10, F3_SW, OP_STORE));
        place_instr(itype(12'h678, 5'd1, F3_ADD, 5'd2, OP_OPIMM));
        place_instr(stype(12'd4, 5'd2, 5'd10, F3_SW, OP_STORE));
        place_instr(itype(12'hFFB, 5'd0, F3_ADD, 5'd3, OP_OPIMM));      // x3 = -5
        place_instr(rtype(7'd0, 5'd3, 5'd2, F3_ADD, 5'd4, OP_OP));
        place_instr(stype(12'd8, 5'd4, 5'd10, F3_SW, OP_STORE));
        place_instr(rtype(F7_SUB, 5'd2, 5'd3, F3_ADD, 5'd5, OP_OP));    // x5 = x3 - x2
        place_instr(stype(12'd12, 5'd5, 5'd10, F3_SW, OP_STORE));
        place_instr(itype(LOAD_ADDR[11:0], 5'd0, F3_LW, 5'd6, OP_LOAD));
        place_instr(itype(12'h123, 5'd6, F3_ADD, 5'd7, OP_OPIMM));
        place_instr(stype(12'd16, 5'd7, 5'd10, F3_SW, OP_STORE));
        place_instr(itype(12'd0, 5'd0, F3_ADD, 5'd8, OP_OPIMM));
        place_instr(itype(12'd5, 5'd0, F3_ADD, 5'd9, OP_OPIMM));
        place_instr(itype(12'd20, 5'd10, F3_ADD, 5'd11, OP_OPIMM));
        place_instr(itype(12'd1, 5'd8, F3_ADD, 5'd8, OP_OPIMM));        // loop top
        place_instr(stype(12'd0, 5'd8, 5'd11, F3_SW, OP_STORE));
        place_instr(itype(12'd4, 5'd11, F3_ADD, 5'd11, OP_OPIMM));
        place_instr(btype(13'h1FF4, 5'd9, 5'd8, F3_BNE, OP_BRANCH));    // back three words
        place_instr(stype(12'd0, 5'd10, 5'd11, F3_SW, OP_STORE));       // wrong-path probe
        place_instr(itype(12'h5A5, 5'd0, F3_ADD, 5'd12, OP_OPIMM));
        place_instr(itype(CSR_MSCRATCH, 5'd12, F3_CSRRW, 5'd0, OP_SYSTEM));
        place_instr(itype(CSR_MSCRATCH, 5'd0, F3_CSRRS, 5'd13, OP_SYSTEM));
        place_instr(stype(12'd44, 5'd13, 5'd10, F3_SW, OP_STORE));
        place_instr(itype(CSR_MINSTRET, 5'd0, F3_CSRRS, 5'd14, OP_SYSTEM));
        place_instr(stype(12'd48, 5'd14, 5'd10, F3_SW, OP_STORE));
        place_instr(itype(CSR_MCYCLE, 5'd0, F3_CSRRS, 5'd15, OP_SYSTEM));
        place_instr(itype(CSR_MCYCLE, 5'd0, F3_CSRRS, 5'd16, OP_SYSTEM));
        place_instr(stype(12'd52, 5'd15, 5'd10, F3_SW, OP_STORE));
        place_instr(stype(12'd56, 5'd16, 5'd10, F3_SW, OP_STORE));
        place_instr(itype(12'd1, 5'd0, F3_ADD, 5'd1, OP_OPIMM));
        place_instr(btype(13'd0, 5'd1, 5'd0, F3_BNE, OP_BRANCH));       // spin here
        u_mem.mem[LOAD_ADDR[9:2]] = LOAD_WORD;
    endtask

    task automatic build_expected();
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x3;
        x1 = 32'h1234_5000;
        x2 = x1 + 32'h678;
        x3 = 32'd0 - 32'd5;
        expect_store(STORE_BASE, x1, K_EXACT);
        expect_store(STORE_BASE + 32'h04, x2, K_EXACT);
        expect_store(STORE_BASE + 32'h08, x2 + x3, K_EXACT);
        expect_store(STORE_BASE + 32'h0C, x3 - x2, K_EXACT);
        expect_store(STORE_BASE + 32'h10, LOAD_WORD + 32'h123, K_EXACT);
        for (int k = 1; k <= 5; k++)
            expect_store(STORE_BASE + 32'h10 + 32'(4 * k), 32'(k), K_EXACT);
        expect_store(STORE_BASE + 32'h28, STORE_BASE, K_EXACT);
        expect_store(STORE_BASE + 32'h2C, 32'h5A5, K_EXACT);
        // sixteen straight-line, five passes of four, five more before the read
        expect_store(STORE_BASE + 32'h30, 32'(16 + 5 * 4 + 5), K_EXACT);
        expect_store(STORE_BASE + 32'h34, 32'h0, K_FIRST);
        expect_store(STORE_BASE + 32'h38, 32'h0, K_LATER);
    endtask

    //////////////////////////////
    // store checker
    always @(posedge clk)
    begin
        if (rst_n && wb_cyc && wb_stb && wb_we && wb_ack)
        begin
            a_store_count: assert (n_seen < exp_addr.size())
            else
            begin
                $display("unexpected store to %h at %0t after all expected stores", wb_adr, $time);
                $display("RESULT: FAIL");
                $fatal(1, "extra store");
            end
            a_store_addr: assert (wb_adr == exp_addr[n_seen])
            else
            begin
                $display("MISMATCH at %0t: o_wb_adr expected %h, got %h",
                         $time, exp_addr[n_seen], wb_adr);
                $display("RESULT: FAIL");
                $fatal(1, "store address");
            end
            if (exp_kind[n_seen] == K_FIRST)
                mcycle_first <= wb_dat_w;
            else if (exp_kind[n_seen] == K_LATER)
            begin
                a_mcycle_grows: assert (wb_dat_w > mcycle_first)
                else
                begin
                    $display("MISMATCH at %0t: o_wb_dat expected above %h, got %h",
                             $time, mcycle_first, wb_dat_w);
                    $display("RESULT: FAIL");
                    $fatal(1, "mcycle order");
                end
            end
            else
            begin
                a_store_data: assert (wb_dat_w == exp_data[n_seen])
                else
                begin
                    $display("MISMATCH at %0t: o_wb_dat expected %h, got %h",
                             $time, exp_data[n_seen], wb_dat_w);
                    $display("RESULT: FAIL");
                    $fatal(1, "store data");
                end
            end
            n_seen <= n_seen + 1;
        end
    end

    //////////////////////////////
    // bus protocol
    a_reset_idle: assert property (@(posedge clk)
        (cycles > 0 && (!rst_n || !rst_d)) |-> (!wb_cyc && !wb_stb && !wb_we))
    else
    begin
        $display("Wishbone cycle active during or right after reset at %0t", $time);
        $display("RESULT: FAIL");
        $fatal(1, "reset state");
    end

    a_stb_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)))
    else
    begin
        $display("o_wb_stb or o_wb_adr changed before i_wb_ack at %0t", $time);
        $display("RESULT: FAIL");
        $fatal(1, "bus hold");
    end

    a_sel_full: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && wb_stb && !wb_we && wb_adr < PROG_BYTES) |-> (wb_sel == 4'hF))
    else
    begin
        $display("MISMATCH at %0t: o_wb_sel expected %h, got %h", $time, 4'hF, $sampled(wb_sel));
        $display("RESULT: FAIL");
        $fatal(1, "byte select");
    end

    initial
    begin
        rst_n = 1'b0;
        load_program();
        build_expected();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        while (n_seen < exp_addr.size() && cycles < TIMEOUT_CYCLES)
            @(posedge clk);
        if (n_seen == exp_addr.size())
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("timeout after %0d cycles, %0d of %0d stores seen",
                     cycles, n_seen, exp_addr.size());
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

endmodule

// File: sim/tb_wb_mem.sv
`timescale 1ns/1ps

module tb_wb_mem
#(
    parameter logic [31:0] SEED = 32'h0b42c883
)
(
    input  wire         i_clk,
    input  wire         i_arst_n,
    input  wire  [31:0] i_wb_adr,
    input  wire  [31:0] i_wb_dat,
    input  wire         i_wb_we,
    input  wire  [3:0]  i_wb_sel,
    input  wire         i_wb_stb,
    input  wire         i_wb_cyc,
    output logic [31:0] o_wb_dat,
    output logic        o_wb_ack
);

    logic [31:0] mem [0:255];       // loaded by the testbench
    logic [31:0] lcg;
    logic [1:0]  wait_cnt;
    logic        accept;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // top two bits of the generator give the ack delay
    assign accept = i_arst_n && i_wb_cyc && i_wb_stb && !o_wb_ack && (wait_cnt == lcg[31:30]);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            lcg      <= SEED;
            wait_cnt <= '0;
            o_wb_ack <= 1'b0;
        end
        else
        begin
            o_wb_ack <= accept;         // single-cycle ack
            if (accept)
            begin
                wait_cnt <= '0;
                lcg      <= lcg_next(lcg);
            end
            else if (i_wb_cyc && i_wb_stb && !o_wb_ack)
                wait_cnt <= wait_cnt + 2'd1;
        end
    end

    always @(posedge i_clk)
    begin
        if (accept)
        begin
            o_wb_dat <= mem[i_wb_adr[9:2]];
            if (i_wb_we)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (i_wb_sel[b])        // byte lanes
                        mem[i_wb_adr[9:2]][8*b +: 8] <= i_wb_dat[8*b +: 8];
                end
            end
        end
    end

endmodule
